// ==== common/stream_pkg.sv ====
package stream_pkg;

    // side fields carried on every stream port
    localparam int user_width = 2;
    localparam int tid_width  = 2;

    // tid stamped on upstream beats, same code routes downstream beats
    typedef enum logic [tid_width-1:0] {
        src_user_project   = 2'd0,
        src_axilite        = 2'd1,
        src_logic_analyzer = 2'd2
    } source_id_e;

endpackage

// ==== common/arb_pkg.sv ====
package arb_pkg;

    // user project, axilite bridge, logic analyzer
    localparam int num_sources = 3;

    // state bit that marks a live grant
    localparam int grant_flag = num_sources;

    // low bits one-hot; in a wait state they name the source served last
    typedef enum logic [3:0] {
        wait_0  = 4'b0001,
        wait_1  = 4'b0010,
        wait_2  = 4'b0100,
        grant_0 = 4'b1001,
        grant_1 = 4'b1010,
        grant_2 = 4'b1100
    } grant_state_e;

endpackage

// ==== upstream/grant_fsm.sv ====
`timescale 1ns/10ps

module grant_fsm (
    input  logic                            axis_clk,
    input  logic                            axi_reset_n,
    input  logic [arb_pkg::num_sources-1:0] req,
    input  logic [arb_pkg::num_sources-1:0] hi_req,
    input  logic                            last_accept,
    input  logic                            burst_done,
    output logic [arb_pkg::num_sources-1:0] grant
);
    import arb_pkg::*;

    grant_state_e           state;
    grant_state_e           state_next;
    logic [num_sources-1:0] hp_pick;
    logic [num_sources-1:0] np_pick;

    // first set bit of mask after the last served source, wrapping around
    function automatic logic [num_sources-1:0] rotate_pick(
        input logic [num_sources-1:0] mask,
        input logic [num_sources-1:0] last
    );
        logic [num_sources-1:0] pick;
        int                     base;
        int                     pos;
        pick = '0;
        base = 0;
        for (int k = 0; k < num_sources; k++) begin
            if (last[k]) begin
                base = k;
            end
        end
        // farthest first, so the nearest requester overwrites the pick
        for (int i = num_sources; i >= 1; i--) begin
            pos = (base + i) % num_sources;
            if (mask[pos]) begin
                pick      = '0;
                pick[pos] = 1'b1;
            end
        end
        return pick;
    endfunction

    // high priority only counts when the source has a beat ready
    assign hp_pick = rotate_pick(req & hi_req, state[num_sources-1:0]);
    assign np_pick = rotate_pick(req, state[num_sources-1:0]);

    assign grant = state[grant_flag] ? state[num_sources-1:0] : '0;

    always_comb begin
        state_next = state;
        if (!state[grant_flag]) begin
            if (|hp_pick) begin
                state_next = grant_state_e'({1'b1, hp_pick});
            end else if (|np_pick) begin
                state_next = grant_state_e'({1'b1, np_pick});
            end
        end else if (last_accept || burst_done) begin
            // drop the flag, keep the served source for the next rotation
            state_next = grant_state_e'({1'b0, state[num_sources-1:0]});
        end
    end

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            state <= wait_0;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== upstream/burst_counter.sv ====
`timescale 1ns/10ps

module burst_counter #(
    parameter int max_beats = 7
) (
    input  logic                            axis_clk,
    input  logic                            axi_reset_n,
    input  logic [arb_pkg::num_sources-1:0] grant,
    input  logic [arb_pkg::num_sources-1:0] hi_req,
    input  logic                            beat_accept,
    output logic                            burst_done
);
    localparam int cnt_width = $clog2(max_beats + 1);

    logic [cnt_width-1:0] count;
    logic [cnt_width-1:0] count_next;
    logic                 normal_grant;

    // high-priority grants run to tlast and are never capped
    assign normal_grant = (|grant) && !(|(grant & hi_req));
    assign count_next   = count + 1'b1;

    // the beat that brings the count to max_beats closes the grant
    assign burst_done = normal_grant && beat_accept &&
                        (count_next == cnt_width'(max_beats));

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            count <= '0;
        end else if (!normal_grant) begin
            count <= '0;
        end else if (beat_accept) begin
            count <= count_next;
        end
    end

endmodule

// ==== upstream/upstream_mux.sv ====
`timescale 1ns/10ps

module upstream_mux #(
    parameter int data_width = 32
) (
    input  logic [data_width-1:0]             up_as_tdata,
    input  logic [data_width/8-1:0]           up_as_tstrb,
    input  logic [data_width/8-1:0]           up_as_tkeep,
    input  logic                              up_as_tlast,
    input  logic                              up_as_tvalid,
    input  logic [stream_pkg::user_width-1:0] up_as_tuser,
    input  logic [data_width-1:0]             aa_as_tdata,
    input  logic [data_width/8-1:0]           aa_as_tstrb,
    input  logic [data_width/8-1:0]           aa_as_tkeep,
    input  logic                              aa_as_tlast,
    input  logic                              aa_as_tvalid,
    input  logic [stream_pkg::user_width-1:0] aa_as_tuser,
    input  logic [data_width-1:0]             la_as_tdata,
    input  logic [data_width/8-1:0]           la_as_tstrb,
    input  logic [data_width/8-1:0]           la_as_tkeep,
    input  logic                              la_as_tlast,
    input  logic                              la_as_tvalid,
    input  logic [stream_pkg::user_width-1:0] la_as_tuser,
    input  logic [arb_pkg::num_sources-1:0]   grant,
    input  logic                              is_as_tready,
    output logic                              as_up_tready,
    output logic                              as_aa_tready,
    output logic                              as_la_tready,
    output logic [data_width-1:0]             as_is_tdata,
    output logic [data_width/8-1:0]           as_is_tstrb,
    output logic [data_width/8-1:0]           as_is_tkeep,
    output logic                              as_is_tlast,
    output logic                              as_is_tvalid,
    output logic [stream_pkg::user_width-1:0] as_is_tuser,
    output stream_pkg::source_id_e            as_is_tid,
    output logic                              beat_accept,
    output logic                              last_accept
);
    import stream_pkg::*;

    // only the granted source sees the serializer's ready
    assign as_up_tready = is_as_tready & grant[0];
    assign as_aa_tready = is_as_tready & grant[1];
    assign as_la_tready = is_as_tready & grant[2];

    assign beat_accept = as_is_tvalid & is_as_tready;
    assign last_accept = beat_accept & as_is_tlast;

    always_comb begin
        as_is_tdata  = '0;
        as_is_tstrb  = '0;
        as_is_tkeep  = '0;
        as_is_tlast  = 1'b0;
        as_is_tvalid = 1'b0;
        as_is_tuser  = '0;
        as_is_tid    = src_user_project;
        case (grant)
            3'b001: begin
                as_is_tdata  = up_as_tdata;
                as_is_tstrb  = up_as_tstrb;
                as_is_tkeep  = up_as_tkeep;
                as_is_tlast  = up_as_tlast;
                as_is_tvalid = up_as_tvalid;
                as_is_tuser  = up_as_tuser;
            end
            3'b010: begin
                as_is_tdata  = aa_as_tdata;
                as_is_tstrb  = aa_as_tstrb;
                as_is_tkeep  = aa_as_tkeep;
                as_is_tlast  = aa_as_tlast;
                as_is_tvalid = aa_as_tvalid;
                as_is_tuser  = aa_as_tuser;
                as_is_tid    = src_axilite;
            end
            3'b100: begin
                as_is_tdata  = la_as_tdata;
                as_is_tstrb  = la_as_tstrb;
                as_is_tkeep  = la_as_tkeep;
                as_is_tlast  = la_as_tlast;
                as_is_tvalid = la_as_tvalid;
                as_is_tuser  = la_as_tuser;
                as_is_tid    = src_logic_analyzer;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== downstream/downstream_queue.sv ====
`timescale 1ns/10ps

module downstream_queue #(
    parameter int data_width = 32,
    parameter int fifo_depth = 16
) (
    input  logic                              axis_clk,
    input  logic                              axi_reset_n,
    input  logic [data_width-1:0]             is_as_tdata,
    input  logic [data_width/8-1:0]           is_as_tstrb,
    input  logic [data_width/8-1:0]           is_as_tkeep,
    input  logic                              is_as_tlast,
    input  logic [stream_pkg::tid_width-1:0]  is_as_tid,
    input  logic                              is_as_tvalid,
    input  logic [stream_pkg::user_width-1:0] is_as_tuser,
    output logic                              as_is_tready,
    output logic [data_width-1:0]             as_up_tdata,
    output logic [data_width/8-1:0]           as_up_tstrb,
    output logic [data_width/8-1:0]           as_up_tkeep,
    output logic                              as_up_tlast,
    output logic                              as_up_tvalid,
    output logic [stream_pkg::user_width-1:0] as_up_tuser,
    input  logic                              up_as_tready,
    output logic [data_width-1:0]             as_aa_tdata,
    output logic [data_width/8-1:0]           as_aa_tstrb,
    output logic [data_width/8-1:0]           as_aa_tkeep,
    output logic                              as_aa_tlast,
    output logic                              as_aa_tvalid,
    output logic [stream_pkg::user_width-1:0] as_aa_tuser,
    input  logic                              aa_as_tready
);
    import stream_pkg::*;

    localparam int addr_width = $clog2(fifo_depth);
    localparam int keep_width = data_width / 8;
    localparam int beat_width = data_width + 2 * keep_width + 1 + tid_width + user_width;

    logic [beat_width-1:0] mem [fifo_depth];
    logic [addr_width:0]   wr_ptr;
    logic [addr_width:0]   rd_ptr;
    logic                  full;
    logic                  empty;
    logic                  push;
    logic                  pop;
    logic                  up_sel;
    logic                  aa_sel;
    logic [data_width-1:0] head_data;
    logic [keep_width-1:0] head_strb;
    logic [keep_width-1:0] head_keep;
    logic                  head_last;
    logic [tid_width-1:0]  head_tid;
    logic [user_width-1:0] head_user;

    // pointers carry one extra wrap bit to tell full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[addr_width] != rd_ptr[addr_width]) &&
                   (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);

    assign as_is_tready = !full;
    assign push         = is_as_tvalid && as_is_tready;

    assign {head_user, head_tid, head_last, head_keep, head_strb, head_data} =
        mem[rd_ptr[addr_width-1:0]];

    // tid 2 and 3 match neither output and hold the head
    assign up_sel = !empty && (head_tid == src_user_project);
    assign aa_sel = !empty && (head_tid == src_axilite);
    assign pop    = (up_sel && up_as_tready) || (aa_sel && aa_as_tready);

    assign as_up_tvalid = up_sel;
    assign as_up_tdata  = up_sel ? head_data : '0;
    assign as_up_tstrb  = up_sel ? head_strb : '0;
    assign as_up_tkeep  = up_sel ? head_keep : '0;
    assign as_up_tlast  = up_sel && head_last;
    assign as_up_tuser  = up_sel ? head_user : '0;

    assign as_aa_tvalid = aa_sel;
    assign as_aa_tdata  = aa_sel ? head_data : '0;
    assign as_aa_tstrb  = aa_sel ? head_strb : '0;
    assign as_aa_tkeep  = aa_sel ? head_keep : '0;
    assign as_aa_tlast  = aa_sel && head_last;
    assign as_aa_tuser  = aa_sel ? head_user : '0;

    always_ff @(posedge axis_clk) begin
        if (push) begin
            mem[wr_ptr[addr_width-1:0]] <=
                {is_as_tuser, is_as_tid, is_as_tlast, is_as_tkeep, is_as_tstrb, is_as_tdata};
        end
    end

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== logic/axis_switch.sv ====
`timescale 1ns/10ps

module axis_switch #(
    parameter int data_width = 32,
    parameter int fifo_depth = 16,
    parameter int max_beats  = 7
) (
    input  logic                              axis_clk,
    input  logic                              axi_reset_n,
    // user project source, tid 0
    input  logic [data_width-1:0]             up_as_tdata,
    input  logic [data_width/8-1:0]           up_as_tstrb,
    input  logic [data_width/8-1:0]           up_as_tkeep,
    input  logic                              up_as_tlast,
    input  logic                              up_as_tvalid,
    input  logic [stream_pkg::user_width-1:0] up_as_tuser,
    input  logic                              up_hpri_req,
    output logic                              as_up_tready,
    // axilite bridge source, tid 1
    input  logic [data_width-1:0]             aa_as_tdata,
    input  logic [data_width/8-1:0]           aa_as_tstrb,
    input  logic [data_width/8-1:0]           aa_as_tkeep,
    input  logic                              aa_as_tlast,
    input  logic                              aa_as_tvalid,
    input  logic [stream_pkg::user_width-1:0] aa_as_tuser,
    output logic                              as_aa_tready,
    // logic analyzer source, tid 2
    input  logic [data_width-1:0]             la_as_tdata,
    input  logic [data_width/8-1:0]           la_as_tstrb,
    input  logic [data_width/8-1:0]           la_as_tkeep,
    input  logic                              la_as_tlast,
    input  logic                              la_as_tvalid,
    input  logic [stream_pkg::user_width-1:0] la_as_tuser,
    input  logic                              la_hpri_req,
    output logic                              as_la_tready,
    // link toward the serializer
    output logic [data_width-1:0]             as_is_tdata,
    output logic [data_width/8-1:0]           as_is_tstrb,
    output logic [data_width/8-1:0]           as_is_tkeep,
    output logic                              as_is_tlast,
    output stream_pkg::source_id_e            as_is_tid,
    output logic                              as_is_tvalid,
    output logic [stream_pkg::user_width-1:0] as_is_tuser,
    input  logic                              is_as_tready,
    // beats from the serializer
    input  logic [data_width-1:0]             is_as_tdata,
    input  logic [data_width/8-1:0]           is_as_tstrb,
    input  logic [data_width/8-1:0]           is_as_tkeep,
    input  logic                              is_as_tlast,
    input  logic [stream_pkg::tid_width-1:0]  is_as_tid,
    input  logic                              is_as_tvalid,
    input  logic [stream_pkg::user_width-1:0] is_as_tuser,
    output logic                              as_is_tready,
    // user project destination
    output logic [data_width-1:0]             as_up_tdata,
    output logic [data_width/8-1:0]           as_up_tstrb,
    output logic [data_width/8-1:0]           as_up_tkeep,
    output logic                              as_up_tlast,
    output logic                              as_up_tvalid,
    output logic [stream_pkg::user_width-1:0] as_up_tuser,
    input  logic                              up_as_tready,
    // axilite destination
    output logic [data_width-1:0]             as_aa_tdata,
    output logic [data_width/8-1:0]           as_aa_tstrb,
    output logic [data_width/8-1:0]           as_aa_tkeep,
    output logic                              as_aa_tlast,
    output logic                              as_aa_tvalid,
    output logic [stream_pkg::user_width-1:0] as_aa_tuser,
    input  logic                              aa_as_tready
);
    import stream_pkg::*;
    import arb_pkg::*;

    logic [num_sources-1:0] req;
    logic [num_sources-1:0] hi_req;
    logic [num_sources-1:0] grant;
    logic                   beat_accept;
    logic                   last_accept;
    logic                   burst_done;

    // a pending beat is the request
    assign req[src_user_project]   = up_as_tvalid;
    assign req[src_axilite]        = aa_as_tvalid;
    assign req[src_logic_analyzer] = la_as_tvalid;

    // axilite bridge has no high-priority line
    assign hi_req[src_user_project]   = up_hpri_req;
    assign hi_req[src_axilite]        = 1'b0;
    assign hi_req[src_logic_analyzer] = la_hpri_req;

    grant_fsm u_grant_fsm (.*);

    burst_counter #(
        .max_beats(max_beats)
    ) u_burst_counter (.*);

    upstream_mux #(
        .data_width(data_width)
    ) u_upstream_mux (.*);

    downstream_queue #(
        .data_width(data_width),
        .fifo_depth(fifo_depth)
    ) u_downstream_queue (.*);

endmodule

// ==== testbench/tb_axis_switch.sv ====
`timescale 1ns/10ps

module tb_axis_switch;

    localparam int clk_period = 20;
    localparam int fifo_depth = 16;

    logic        axis_clk;
    logic        axi_reset_n;
    // upstream sources, index is the tid
    logic [31:0] src_tdata  [3];
    logic [3:0]  src_tstrb  [3];
    logic [3:0]  src_tkeep  [3];
    logic        src_tlast  [3];
    logic        src_tvalid [3];
    logic [1:0]  src_tuser  [3];
    logic        src_hpri   [3];
    logic        src_tready [3];
    logic [31:0] as_is_tdata;
    logic [3:0]  as_is_tstrb;
    logic [3:0]  as_is_tkeep;
    logic        as_is_tlast;
    logic [1:0]  as_is_tid;
    logic        as_is_tvalid;
    logic [1:0]  as_is_tuser;
    logic        is_as_tready;
    // downstream side
    logic [31:0] is_as_tdata;
    logic [3:0]  is_as_tstrb;
    logic [3:0]  is_as_tkeep;
    logic        is_as_tlast;
    logic [1:0]  is_as_tid;
    logic        is_as_tvalid;
    logic [1:0]  is_as_tuser;
    logic        as_is_tready;
    logic [31:0] as_up_tdata;
    logic [3:0]  as_up_tstrb;
    logic [3:0]  as_up_tkeep;
    logic        as_up_tlast;
    logic        as_up_tvalid;
    logic [1:0]  as_up_tuser;
    logic        up_as_tready;
    logic [31:0] as_aa_tdata;
    logic [3:0]  as_aa_tstrb;
    logic [3:0]  as_aa_tkeep;
    logic        as_aa_tlast;
    logic        as_aa_tvalid;
    logic [1:0]  as_aa_tuser;
    logic        aa_as_tready;

    // frames per source and the expected grant segments on as_is
    logic [31:0] words [3][16];
    int          len   [3];
    int          pos   [3];
    int          exp_src [$];
    int          exp_cnt [$];
    // downstream beats, fed and expected in the same order
    logic [1:0]  ds_tid  [$];
    logic        ds_last [$];
    logic [31:0] ds_data [$];
    // parsed pattern lines
    byte         cmd_c [$];
    int          cmd_a [$];
    int          cmd_b [$];
    int          cmd_d [$];
    logic [31:0] cmd_e [$];
    logic [31:0] lfsr_state;
    int          watchdog_cycles;
    string       tready_name [3];

    axis_switch uut (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .up_as_tdata  (src_tdata[0]),
        .up_as_tstrb  (src_tstrb[0]),
        .up_as_tkeep  (src_tkeep[0]),
        .up_as_tlast  (src_tlast[0]),
        .up_as_tvalid (src_tvalid[0]),
        .up_as_tuser  (src_tuser[0]),
        .up_hpri_req  (src_hpri[0]),
        .as_up_tready (src_tready[0]),
        .aa_as_tdata  (src_tdata[1]),
        .aa_as_tstrb  (src_tstrb[1]),
        .aa_as_tkeep  (src_tkeep[1]),
        .aa_as_tlast  (src_tlast[1]),
        .aa_as_tvalid (src_tvalid[1]),
        .aa_as_tuser  (src_tuser[1]),
        .as_aa_tready (src_tready[1]),
        .la_as_tdata  (src_tdata[2]),
        .la_as_tstrb  (src_tstrb[2]),
        .la_as_tkeep  (src_tkeep[2]),
        .la_as_tlast  (src_tlast[2]),
        .la_as_tvalid (src_tvalid[2]),
        .la_as_tuser  (src_tuser[2]),
        .la_hpri_req  (src_hpri[2]),
        .as_la_tready (src_tready[2]),
        .as_is_tdata  (as_is_tdata),
        .as_is_tstrb  (as_is_tstrb),
        .as_is_tkeep  (as_is_tkeep),
        .as_is_tlast  (as_is_tlast),
        .as_is_tid    (as_is_tid),
        .as_is_tvalid (as_is_tvalid),
        .as_is_tuser  (as_is_tuser),
        .is_as_tready (is_as_tready),
        .is_as_tdata  (is_as_tdata),
        .is_as_tstrb  (is_as_tstrb),
        .is_as_tkeep  (is_as_tkeep),
        .is_as_tlast  (is_as_tlast),
        .is_as_tid    (is_as_tid),
        .is_as_tvalid (is_as_tvalid),
        .is_as_tuser  (is_as_tuser),
        .as_is_tready (as_is_tready),
        .as_up_tdata  (as_up_tdata),
        .as_up_tstrb  (as_up_tstrb),
        .as_up_tkeep  (as_up_tkeep),
        .as_up_tlast  (as_up_tlast),
        .as_up_tvalid (as_up_tvalid),
        .as_up_tuser  (as_up_tuser),
        .up_as_tready (up_as_tready),
        .as_aa_tdata  (as_aa_tdata),
        .as_aa_tstrb  (as_aa_tstrb),
        .as_aa_tkeep  (as_aa_tkeep),
        .as_aa_tlast  (as_aa_tlast),
        .as_aa_tvalid (as_aa_tvalid),
        .as_aa_tuser  (as_aa_tuser),
        .aa_as_tready (aa_as_tready)
    );

    initial begin
        axis_clk = 1'b0;
        forever begin
            #(clk_period / 2) axis_clk = ~axis_clk;
        end
    end

    // galois form, taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic next_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // strb, keep and tuser come from fixed bits of the payload word
    task automatic drive_sources();
        logic [31:0] w;
        for (int k = 0; k < 3; k++) begin
            w = (pos[k] < len[k]) ? words[k][pos[k]] : 32'h0;
            src_tvalid[k] = (pos[k] < len[k]);
            src_tdata[k]  = w;
            src_tstrb[k]  = w[3:0];
            src_tkeep[k]  = w[7:4];
            src_tuser[k]  = w[9:8];
            src_tlast[k]  = (pos[k] < len[k]) && (pos[k] == len[k] - 1);
            if (pos[k] >= len[k]) begin
                src_hpri[k] = 1'b0;
            end
        end
    endtask

    task automatic run_upstream();
        int          s;
        logic [31:0] w;
        for (int k = 0; k < 3; k++) begin
            pos[k] = 0;
        end
        @(posedge axis_clk);
        #2;
        drive_sources();
        while (exp_src.size() > 0) begin
            @(negedge axis_clk);
            if (as_is_tvalid) begin
                s = exp_src[0];
                w = words[s][pos[s]];
                check_value("as_is_tid", 32'(as_is_tid), 32'(s));
                check_value("as_is_tdata", as_is_tdata, w);
                check_value("as_is_tstrb", 32'(as_is_tstrb), 32'(w[3:0]));
                check_value("as_is_tkeep", 32'(as_is_tkeep), 32'(w[7:4]));
                check_value("as_is_tuser", 32'(as_is_tuser), 32'(w[9:8]));
                check_value("as_is_tlast", 32'(as_is_tlast), 32'(pos[s] == len[s] - 1));
                for (int k = 0; k < 3; k++) begin
                    check_value(tready_name[k], 32'(src_tready[k]), 32'(k == s));
                end
                pos[s] = pos[s] + 1;
                exp_cnt[0] = exp_cnt[0] - 1;
                if (exp_cnt[0] == 0) begin
                    void'(exp_src.pop_front());
                    void'(exp_cnt.pop_front());
                end
            end else begin
                for (int k = 0; k < 3; k++) begin
                    check_value(tready_name[k], 32'(src_tready[k]), 32'h0);
                end
            end
            @(posedge axis_clk);
            #2;
            drive_sources();
        end
        for (int k = 0; k < 3; k++) begin
            len[k] = 0;
        end
    endtask

    task automatic drive_downstream(input int idx);
        logic [31:0] w;
        w = (idx < ds_data.size()) ? ds_data[idx] : 32'h0;
        is_as_tvalid = (idx < ds_data.size());
        is_as_tdata  = w;
        is_as_tstrb  = w[3:0];
        is_as_tkeep  = w[7:4];
        is_as_tuser  = w[9:8];
        is_as_tid    = (idx < ds_data.size()) ? ds_tid[idx] : 2'd0;
        is_as_tlast  = (idx < ds_data.size()) ? ds_last[idx] : 1'b0;
    endtask

    // hold keeps the user project output stalled until the queue is full
    task automatic run_downstream(input int hold);
        int          written;
        int          taken;
        logic [31:0] w;
        written = 0;
        taken = 0;
        @(posedge axis_clk);
        #2;
        up_as_tready = (hold == 0);
        drive_downstream(written);
        while (taken < ds_data.size()) begin
            @(negedge axis_clk);
            // only beats written on earlier edges can be at the head
            if (taken < written) begin
                w = ds_data[taken];
                check_value("as_up_tvalid", 32'(as_up_tvalid), 32'(ds_tid[taken] == 2'd0));
                check_value("as_aa_tvalid", 32'(as_aa_tvalid), 32'(ds_tid[taken] == 2'd1));
                if (ds_tid[taken] == 2'd0) begin
                    check_value("as_up_tdata", as_up_tdata, w);
                    check_value("as_up_tstrb", 32'(as_up_tstrb), 32'(w[3:0]));
                    check_value("as_up_tkeep", 32'(as_up_tkeep), 32'(w[7:4]));
                    check_value("as_up_tuser", 32'(as_up_tuser), 32'(w[9:8]));
                    check_value("as_up_tlast", 32'(as_up_tlast), 32'(ds_last[taken]));
                end else begin
                    check_value("as_aa_tdata", as_aa_tdata, w);
                    check_value("as_aa_tstrb", 32'(as_aa_tstrb), 32'(w[3:0]));
                    check_value("as_aa_tkeep", 32'(as_aa_tkeep), 32'(w[7:4]));
                    check_value("as_aa_tuser", 32'(as_aa_tuser), 32'(w[9:8]));
                    check_value("as_aa_tlast", 32'(as_aa_tlast), 32'(ds_last[taken]));
                end
                if ((as_up_tvalid && up_as_tready) || (as_aa_tvalid && aa_as_tready)) begin
                    taken = taken + 1;
                end
            end else begin
                check_value("as_up_tvalid", 32'(as_up_tvalid), 32'h0);
                check_value("as_aa_tvalid", 32'(as_aa_tvalid), 32'h0);
            end
            if (is_as_tvalid && as_is_tready) begin
                written = written + 1;
            end
            if (hold != 0 && !up_as_tready && is_as_tvalid && !as_is_tready) begin
                check_value("beats accepted before as_is_tready fell",
                            32'(written), 32'(fifo_depth));
                hold = 0;
            end
            @(posedge axis_clk);
            #2;
            up_as_tready = (hold == 0);
            drive_downstream(written);
        end
        ds_tid.delete();
        ds_last.delete();
        ds_data.delete();
    endtask

    task automatic load_patterns();
        int          fd;
        int          a;
        int          b;
        int          d;
        logic [31:0] e;
        byte         c;
        string       line;
        fd = $fopen("testbench/switch_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file testbench/switch_patterns.txt");
            $display("test failed");
            $fatal(1, "missing pattern file");
        end
        while ($fgets(line, fd) != 0) begin
            a = 0;
            b = 0;
            d = 0;
            e = '0;
            c = (line.len() > 0) ? line.getc(0) : 8'h0;
            if (c == "F") begin
                void'($sscanf(line, "%c %d %d %d %h", c, a, b, d, e));
            end else if (c == "E") begin
                void'($sscanf(line, "%c %d %d", c, a, b));
            end else if (c == "D") begin
                void'($sscanf(line, "%c %d %d %h", c, a, b, e));
            end else if (c == "B") begin
                void'($sscanf(line, "%c %d", c, a));
            end
            if (c == "F" || c == "E" || c == "R" || c == "D" || c == "B") begin
                cmd_c.push_back(c);
                cmd_a.push_back(a);
                cmd_b.push_back(b);
                cmd_d.push_back(d);
                cmd_e.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge axis_clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] w;
        tready_name[0] = "as_up_tready";
        tready_name[1] = "as_aa_tready";
        tready_name[2] = "as_la_tready";
        lfsr_state = 32'heeb0;
        axi_reset_n = 1'b0;
        for (int k = 0; k < 3; k++) begin
            len[k] = 0;
            pos[k] = 0;
            src_hpri[k] = 1'b0;
        end
        drive_sources();
        drive_downstream(0);
        is_as_tready = 1'b1;
        up_as_tready = 1'b1;
        aa_as_tready = 1'b1;
        load_patterns();
        watchdog_cycles = 200 * cmd_c.size() + 1000;
        repeat (16) @(posedge axis_clk);
        #2;
        axi_reset_n = 1'b1;
        for (int i = 0; i < cmd_c.size(); i++) begin
            case (cmd_c[i])
                "F": begin
                    for (int j = 0; j < cmd_d[i]; j++) begin
                        next_word(w);
                        words[cmd_a[i]][j] = w ^ cmd_e[i];
                    end
                    len[cmd_a[i]] = cmd_d[i];
                    src_hpri[cmd_a[i]] = (cmd_b[i] != 0);
                end
                "E": begin
                    exp_src.push_back(cmd_a[i]);
                    exp_cnt.push_back(cmd_b[i]);
                end
                "R": run_upstream();
                "D": begin
                    ds_tid.push_back(cmd_a[i][1:0]);
                    ds_last.push_back(cmd_b[i] != 0);
                    ds_data.push_back(cmd_e[i]);
                end
                "B": run_downstream(cmd_a[i]);
                default: begin
                end
            endcase
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== testbench/switch_patterns.txt ====
# F src hpri len seed_hex : queue a frame on a source (0 user project, 1 axilite, 2 analyzer)
# E src beats : next expected grant segment on as_is; R runs the queued frames
# D tid last data_hex : queue a serializer beat; B hold runs them (1 stalls as_up first)
F 0 0 3 00000011
F 1 0 5 00000022
F 2 0 2 00000033
E 1 5
E 2 2
E 0 3
R
F 2 0 4 00000044
E 2 4
R
F 0 0 10 00000055
F 1 0 3 00000066
E 0 7
E 1 3
E 0 3
R
F 2 1 12 00000077
F 0 0 3 00000088
F 1 0 2 00000099
E 2 12
E 0 3
E 1 2
R
D 0 0 12345678
D 1 0 9abcdef0
D 0 1 0f1e2d3c
D 1 1 4b5a6978
D 1 0 cafe0123
D 0 1 beef4567
B 0
D 0 0 a0000001
D 1 0 b0000102
D 0 0 a0000203
D 0 1 a0000304
D 1 1 b0000105
D 0 0 a0000206
D 1 0 b0000307
D 0 0 a0000008
D 0 1 a0000109
D 1 0 b000020a
D 1 1 b000030b
D 0 0 a000000c
D 0 0 a000010d
D 1 0 b000020e
D 0 1 a000030f
D 1 0 b0000010
D 0 0 a0000111
D 1 1 b0000212
B 1

// ==== list.f ====
common/stream_pkg.sv
common/arb_pkg.sv
upstream/grant_fsm.sv
upstream/burst_counter.sv
upstream/upstream_mux.sv
downstream/downstream_queue.sv
logic/axis_switch.sv
testbench/tb_axis_switch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the switch testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f list.f --top-module tb_axis_switch \
    -o sim_axis_switch > build.log 2>&1 \
    && ./obj_dir/sim_axis_switch > sim.log 2>&1 \
    || echo "build or simulation ended with an error"

cat build.log sim.log 2>/dev/null

grep -qx "test passed" sim.log \
    && echo "simulation result: PASS" \
    || { echo "simulation result: FAIL"; exit 1; }
